//--- scoreboard_pkg.sv
`default_nettype none

package scoreboard_pkg;

   // Defaults for the top-level parameters
   localparam int WF_COUNT_DEF   = 8;
   localparam int REG_ADDR_W_DEF = 8;

   // Wavefront id sized for the default wavefront count
   typedef logic [$clog2(WF_COUNT_DEF)-1:0] wfid_t;

   typedef logic [31:0] opcode_t;
   typedef logic [31:0] pc_t;

   typedef logic [7:0] reg_addr_t;

   // Register operand whose wide bit also covers addr+1
   typedef struct packed {
      logic      used;
      logic      wide;
      reg_addr_t addr;
   } operand_t;

   // Instruction as kept in the info table
   typedef struct packed {
      pc_t      pc;
      opcode_t  opcode;
      operand_t src1;
      operand_t src2;
      operand_t dst;
   } instr_t;

   // Pending bits as a base and upper pair per operand
   typedef logic [5:0] dep_bits_t;

   // Offsets of each operand pair inside dep_bits_t
   localparam int DEP_SRC1 = 0;
   localparam int DEP_SRC2 = 2;
   localparam int DEP_DST  = 4;

   // Bit 0 is the base register and bit 1 is base plus one
   typedef logic [1:0] reg_mask_t;

   typedef struct packed {
      logic      valid;
      wfid_t     wfid;
      reg_addr_t addr;
      reg_mask_t mask;
   } wb_t;

endpackage

`default_nettype wire

//--- instr_info_table.sv
`timescale 1ns/100ps
`default_nettype none

module instr_info_table #(
   parameter int WF_COUNT = scoreboard_pkg::WF_COUNT_DEF
) (
   input  logic                          clk,
   input  logic                          rst_n,
   input  logic                          decode_valid,
   input  logic [$clog2(WF_COUNT)-1:0]   decode_wfid,
   input  scoreboard_pkg::instr_t        decode_instr,
   input  logic [$clog2(WF_COUNT)-1:0]   issue_wfid,
   output scoreboard_pkg::instr_t        issued_instr,
   input  logic [$clog2(WF_COUNT)-1:0]   wb_wfid,
   output scoreboard_pkg::instr_t        wb_instr
);
   import scoreboard_pkg::*;

   localparam int WFID_W = $clog2(WF_COUNT);

   // One stored instruction per wavefront
   instr_t entries [WF_COUNT];

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         for (int i = 0; i < WF_COUNT; i++) begin
            entries[i] <= '0;
         end
      end else begin
         for (int i = 0; i < WF_COUNT; i++) begin
            if (decode_valid && (decode_wfid == WFID_W'(i))) begin
               entries[i] <= decode_instr;
            end
         end
      end
   end

   // Issue port goes straight back to the arbiter
   assign issued_instr = entries[issue_wfid];

   // Writeback port feeds the retire comparator
   assign wb_instr = entries[wb_wfid];

endmodule

`default_nettype wire

//--- busy_reg_table.sv
`timescale 1ns/100ps
`default_nettype none

module busy_reg_table #(
   parameter int REG_ADDR_W = scoreboard_pkg::REG_ADDR_W_DEF
) (
   input  logic                      clk,
   input  logic                      rst_n,
   input  scoreboard_pkg::instr_t    decode_instr,
   output scoreboard_pkg::dep_bits_t init_bits,
   input  logic                      issue_valid,
   input  scoreboard_pkg::operand_t  issue_dst,
   input  scoreboard_pkg::wb_t       wb
);
   import scoreboard_pkg::*;

   localparam int NUM_REGS = 2 ** REG_ADDR_W;

   logic [NUM_REGS-1:0]   busy;
   logic [NUM_REGS-1:0]   busy_eff;
   logic [NUM_REGS-1:0]   set_vec;
   logic [NUM_REGS-1:0]   clr_vec;
   logic [REG_ADDR_W-1:0] wb_base;
   logic [REG_ADDR_W-1:0] wb_upper;
   logic [REG_ADDR_W-1:0] dst_base;
   logic [REG_ADDR_W-1:0] dst_upper;

   // Busy state of an operand's base and upper register
   function automatic logic [1:0] op_busy(operand_t op, logic [NUM_REGS-1:0] state);
      logic [REG_ADDR_W-1:0] lo;
      logic [REG_ADDR_W-1:0] hi;
      lo = REG_ADDR_W'(op.addr);
      hi = lo + 1'b1;
      op_busy[0] = op.used & state[lo];
      op_busy[1] = op.used & op.wide & state[hi];
   endfunction

   assign wb_base   = REG_ADDR_W'(wb.addr);
   assign wb_upper  = wb_base + 1'b1;
   assign dst_base  = REG_ADDR_W'(issue_dst.addr);
   assign dst_upper = dst_base + 1'b1;

   always_comb begin
      clr_vec = '0;
      set_vec = '0;
      if (wb.valid) begin
         if (wb.mask[0]) begin
            clr_vec[wb_base] = 1'b1;
         end
         if (wb.mask[1]) begin
            clr_vec[wb_upper] = 1'b1;
         end
      end
      if (issue_valid && issue_dst.used) begin
         set_vec[dst_base] = 1'b1;
         if (issue_dst.wide) begin
            set_vec[dst_upper] = 1'b1;
         end
      end
   end

   // Registers freed this cycle already count as idle for decode
   assign busy_eff = busy & ~clr_vec;

   always_comb begin
      init_bits = '0;
      init_bits[DEP_SRC1 +: 2] = op_busy(decode_instr.src1, busy_eff);
      init_bits[DEP_SRC2 +: 2] = op_busy(decode_instr.src2, busy_eff);
      init_bits[DEP_DST +: 2]  = op_busy(decode_instr.dst, busy_eff);
   end

   // Set is applied after clear, so an issue beats a writeback
   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         busy <= '0;
      end else begin
         busy <= busy_eff | set_vec;
      end
   end

endmodule

`default_nettype wire

//--- retire_comparator.sv
`timescale 1ns/100ps
`default_nettype none

module retire_comparator (
   input  scoreboard_pkg::instr_t    waiting_instr,
   input  scoreboard_pkg::reg_addr_t wb_addr,
   input  scoreboard_pkg::reg_mask_t wb_mask,
   output scoreboard_pkg::dep_bits_t clear_bits
);
   import scoreboard_pkg::*;

   reg_addr_t wb_upper;

   // True when r is one of the registers the writeback names
   function automatic logic reg_hit(
      reg_addr_t r,
      reg_addr_t lo,
      reg_addr_t hi,
      reg_mask_t m
   );
      reg_hit = (m[0] && (r == lo)) || (m[1] && (r == hi));
   endfunction

   function automatic logic [1:0] operand_clear(
      operand_t  op,
      reg_addr_t lo,
      reg_addr_t hi,
      reg_mask_t m
   );
      reg_addr_t upper;
      upper = op.addr + 1'b1;
      operand_clear[0] = reg_hit(op.addr, lo, hi, m);
      operand_clear[1] = reg_hit(upper, lo, hi, m);
   endfunction

   assign wb_upper = wb_addr + 1'b1;

   // Valid gating happens in the dependency table
   always_comb begin
      clear_bits = '0;
      clear_bits[DEP_SRC1 +: 2] = operand_clear(waiting_instr.src1, wb_addr, wb_upper, wb_mask);
      clear_bits[DEP_SRC2 +: 2] = operand_clear(waiting_instr.src2, wb_addr, wb_upper, wb_mask);
      clear_bits[DEP_DST +: 2]  = operand_clear(waiting_instr.dst, wb_addr, wb_upper, wb_mask);
   end

endmodule

`default_nettype wire

//--- dependency_table.sv
`timescale 1ns/100ps
`default_nettype none

module dependency_table #(
   parameter int WF_COUNT = scoreboard_pkg::WF_COUNT_DEF
) (
   input  logic                        clk,
   input  logic                        rst_n,
   input  logic                        decode_valid,
   input  logic [$clog2(WF_COUNT)-1:0] decode_wfid,
   input  scoreboard_pkg::dep_bits_t   init_bits,
   input  logic                        issue_valid,
   input  logic [$clog2(WF_COUNT)-1:0] issue_wfid,
   input  logic                        wb_valid,
   input  logic [$clog2(WF_COUNT)-1:0] wb_wfid,
   input  scoreboard_pkg::dep_bits_t   clear_bits,
   output logic [WF_COUNT-1:0]         ready
);
   import scoreboard_pkg::*;

   localparam int WFID_W = $clog2(WF_COUNT);

   logic [WF_COUNT-1:0] entry_valid;
   dep_bits_t           pending [WF_COUNT];

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         entry_valid <= '0;
         for (int i = 0; i < WF_COUNT; i++) begin
            pending[i] <= '0;
         end
      end else begin
         for (int i = 0; i < WF_COUNT; i++) begin
            // Decode only lands on an empty entry, so it takes priority
            if (decode_valid && (decode_wfid == WFID_W'(i))) begin
               entry_valid[i] <= 1'b1;
               pending[i]     <= init_bits;
            end else begin
               if (issue_valid && (issue_wfid == WFID_W'(i))) begin
                  entry_valid[i] <= 1'b0;
               end
               if (wb_valid && (wb_wfid == WFID_W'(i))) begin
                  pending[i] <= pending[i] & ~clear_bits;
               end
            end
         end
      end
   end

   // Ready once the entry holds an instruction with nothing pending
   always_comb begin
      for (int i = 0; i < WF_COUNT; i++) begin
         ready[i] = entry_valid[i] && (pending[i] == '0);
      end
   end

endmodule

`default_nettype wire

//--- scoreboard.sv
`timescale 1ns/100ps
`default_nettype none

module scoreboard #(
   parameter int WF_COUNT   = scoreboard_pkg::WF_COUNT_DEF,
   parameter int REG_ADDR_W = scoreboard_pkg::REG_ADDR_W_DEF
) (
   input  logic                        clk,
   input  logic                        rst_n,
   input  logic                        decode_valid,
   input  logic [$clog2(WF_COUNT)-1:0] decode_wfid,
   input  scoreboard_pkg::instr_t      decode_instr,
   input  logic                        issue_valid,
   input  logic [$clog2(WF_COUNT)-1:0] issue_wfid,
   output scoreboard_pkg::instr_t      issued_instr,
   input  scoreboard_pkg::wb_t         wb,
   output logic [WF_COUNT-1:0]         ready
);
   import scoreboard_pkg::*;

   localparam int WFID_W = $clog2(WF_COUNT);

   logic [WFID_W-1:0] wb_wfid;
   instr_t            wb_instr;
   dep_bits_t         init_bits;
   dep_bits_t         clear_bits;

   assign wb_wfid = WFID_W'(wb.wfid);

   instr_info_table #(
      .WF_COUNT (WF_COUNT)
   ) u_instr_info_table (
      .clk          (clk),
      .rst_n        (rst_n),
      .decode_valid (decode_valid),
      .decode_wfid  (decode_wfid),
      .decode_instr (decode_instr),
      .issue_wfid   (issue_wfid),
      .issued_instr (issued_instr),
      .wb_wfid      (wb_wfid),
      .wb_instr     (wb_instr)
   );

   // Issued dst comes straight from the table read
   busy_reg_table #(
      .REG_ADDR_W (REG_ADDR_W)
   ) u_busy_reg_table (
      .clk          (clk),
      .rst_n        (rst_n),
      .decode_instr (decode_instr),
      .init_bits    (init_bits),
      .issue_valid  (issue_valid),
      .issue_dst    (issued_instr.dst),
      .wb           (wb)
   );

   retire_comparator u_retire_comparator (
      .waiting_instr (wb_instr),
      .wb_addr       (wb.addr),
      .wb_mask       (wb.mask),
      .clear_bits    (clear_bits)
   );

   dependency_table #(
      .WF_COUNT (WF_COUNT)
   ) u_dependency_table (
      .clk          (clk),
      .rst_n        (rst_n),
      .decode_valid (decode_valid),
      .decode_wfid  (decode_wfid),
      .init_bits    (init_bits),
      .issue_valid  (issue_valid),
      .issue_wfid   (issue_wfid),
      .wb_valid     (wb.valid),
      .wb_wfid      (wb_wfid),
      .clear_bits   (clear_bits),
      .ready        (ready)
   );

endmodule

`default_nettype wire

//--- tb_scoreboard.sv
`timescale 1ns/100ps
`default_nettype none

module tb_scoreboard;
   import scoreboard_pkg::*;

   localparam int RESET_TIMEOUT = 20;
   localparam operand_t NO_OP = '0;

   // One row of the stimulus table
   typedef struct packed {
      logic                    dec_valid;
      wfid_t                   dec_wfid;
      instr_t                  dec_instr;
      logic                    iss_valid;
      wfid_t                   iss_wfid;
      wb_t                     wb;
      logic [WF_COUNT_DEF-1:0] exp_ready;
      pc_t                     exp_pc;
      opcode_t                 exp_opcode;
   } step_t;

   logic                    clk;
   logic                    rst_n;
   logic                    decode_valid;
   wfid_t                   decode_wfid;
   instr_t                  decode_instr;
   logic                    issue_valid;
   wfid_t                   issue_wfid;
   instr_t                  issued_instr;
   wb_t                     wb;
   logic [WF_COUNT_DEF-1:0] ready;

   step_t   steps [$];
   step_t   cur;
   pc_t     pc_of [WF_COUNT_DEF];
   opcode_t op_of [WF_COUNT_DEF];
   integer  seed;

   scoreboard dut (
      .clk          (clk),
      .rst_n        (rst_n),
      .decode_valid (decode_valid),
      .decode_wfid  (decode_wfid),
      .decode_instr (decode_instr),
      .issue_valid  (issue_valid),
      .issue_wfid   (issue_wfid),
      .issued_instr (issued_instr),
      .wb           (wb),
      .ready        (ready)
   );

   always #5 clk = ~clk;

   task automatic check_equal(input logic [63:0] actual, input logic [63:0] expected,
                              input string what);
      if (actual !== expected) begin
         $display("CHECK FAILED at %0d ns: %s, got %0h, expected %0h",
                  $time, what, actual, expected);
         $display("FAIL: see errors above");
         $fatal(1);
      end
   endtask

   function automatic operand_t reg_op(input logic wide, input reg_addr_t addr);
      operand_t op;
      op      = '0;
      op.used = 1'b1;
      op.wide = wide;
      op.addr = addr;
      return op;
   endfunction

   task automatic add_decode(input wfid_t wf, input operand_t s1, input operand_t s2,
                             input operand_t d);
      cur.dec_valid         = 1'b1;
      cur.dec_wfid          = wf;
      cur.dec_instr.pc      = $random(seed);
      cur.dec_instr.opcode  = $random(seed);
      cur.dec_instr.src1    = s1;
      cur.dec_instr.src2    = s2;
      cur.dec_instr.dst     = d;
      // Remember what this wavefront holds for the issue check
      pc_of[wf] = cur.dec_instr.pc;
      op_of[wf] = cur.dec_instr.opcode;
   endtask

   task automatic add_issue(input wfid_t wf);
      cur.iss_valid  = 1'b1;
      cur.iss_wfid   = wf;
      cur.exp_pc     = pc_of[wf];
      cur.exp_opcode = op_of[wf];
   endtask

   task automatic add_wb(input wfid_t wf, input reg_addr_t addr, input reg_mask_t mask);
      cur.wb.valid = 1'b1;
      cur.wb.wfid  = wf;
      cur.wb.addr  = addr;
      cur.wb.mask  = mask;
   endtask

   task automatic push_step(input logic [WF_COUNT_DEF-1:0] exp_ready);
      cur.exp_ready = exp_ready;
      steps.push_back(cur);
      cur = '0;
   endtask

   task automatic build_table();
      cur = '0;
      // Independent decode followed by issue and retire of r20
      add_decode(0, reg_op(0, 10), reg_op(0, 11), reg_op(0, 20));
      push_step(8'h01);
      add_issue(0);
      push_step(8'h00);
      add_wb(0, 20, 2'b01);
      push_step(8'h00);

      // Wide dst at r40 and a reader of r40 and r41 on another wavefront
      add_decode(1, NO_OP, NO_OP, reg_op(1, 40));
      push_step(8'h02);
      add_issue(1);
      push_step(8'h00);
      add_decode(2, reg_op(0, 41), reg_op(1, 40), reg_op(0, 50));
      push_step(8'h00);
      add_wb(2, 40, 2'b01);
      push_step(8'h00);
      add_wb(2, 40, 2'b10);
      push_step(8'h04);
      add_issue(2);
      push_step(8'h00);

      // Decode sees r50 freed by the writeback in the same cycle
      add_decode(0, reg_op(0, 50), NO_OP, reg_op(0, 21));
      add_wb(2, 50, 2'b01);
      push_step(8'h01);

      // Issue marks r21 as an older write to r21 retires and the mark stays
      add_issue(0);
      add_wb(0, 21, 2'b01);
      push_step(8'h00);
      add_decode(1, reg_op(0, 21), NO_OP, NO_OP);
      push_step(8'h00);
      add_wb(1, 21, 2'b01);
      push_step(8'h02);
      add_issue(1);
      push_step(8'h00);

      // Two producers followed by a source waiter and a dst waiter
      add_decode(3, NO_OP, NO_OP, reg_op(0, 60));
      push_step(8'h08);
      add_issue(3);
      add_decode(4, NO_OP, NO_OP, reg_op(0, 70));
      push_step(8'h10);
      add_issue(4);
      push_step(8'h00);
      add_decode(5, reg_op(0, 60), NO_OP, reg_op(0, 80));
      push_step(8'h00);
      add_decode(6, NO_OP, NO_OP, reg_op(0, 70));
      push_step(8'h00);
      add_wb(6, 70, 2'b01);
      push_step(8'h40);
      push_step(8'h40);
      add_wb(5, 60, 2'b01);
      push_step(8'h60);
      add_issue(6);
      push_step(8'h20);
      add_issue(5);
      push_step(8'h00);
   endtask

   task automatic apply_step(input step_t s);
      decode_valid = s.dec_valid;
      decode_wfid  = s.dec_wfid;
      decode_instr = s.dec_instr;
      issue_valid  = s.iss_valid;
      issue_wfid   = s.iss_wfid;
      wb           = s.wb;
   endtask

   // Reset held low for two clock cycles
   initial begin
      rst_n = 1'b0;
      repeat (2) @(posedge clk);
      @(negedge clk);
      rst_n = 1'b1;
   end

   initial begin
      int wait_cycles;
      int idx;
      clk          = 1'b0;
      decode_valid = 1'b0;
      decode_wfid  = '0;
      decode_instr = '0;
      issue_valid  = 1'b0;
      issue_wfid   = '0;
      wb           = '0;
      seed         = 32'h2b77;
      for (idx = 0; idx < WF_COUNT_DEF; idx++) begin
         pc_of[idx] = '0;
         op_of[idx] = '0;
      end

      build_table();

      wait_cycles = 0;
      while (rst_n !== 1'b1) begin
         @(posedge clk);
         wait_cycles++;
         if (wait_cycles > RESET_TIMEOUT) begin
            $display("Timeout: reset was not released within %0d cycles", RESET_TIMEOUT);
            $display("FAIL: see errors above");
            $fatal(1);
         end
      end
      #1;
      check_equal(ready, '0, "ready after reset");

      for (idx = 0; idx < steps.size(); idx++) begin
         @(negedge clk);
         apply_step(steps[idx]);
         #1;
         if (steps[idx].iss_valid) begin
            check_equal(issued_instr.pc, steps[idx].exp_pc,
                        $sformatf("step %0d issued pc", idx));
            check_equal(issued_instr.opcode, steps[idx].exp_opcode,
                        $sformatf("step %0d issued opcode", idx));
         end
         @(posedge clk);
         #1;
         check_equal(ready, steps[idx].exp_ready, $sformatf("step %0d ready", idx));
      end

      @(negedge clk);
      apply_step('0);
      $display("PASS: all tests");
      $finish;
   end

endmodule

`default_nettype wire

//--- files.f
scoreboard_pkg.sv
instr_info_table.sv
busy_reg_table.sv
retire_comparator.sv
dependency_table.sv
scoreboard.sv
tb_scoreboard.sv
